// ==== src/cache_config.svh ====
// cache geometry
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// byte offset within a line
`define CACHE_S_OFFSET 5

// set index bits
`define CACHE_S_INDEX 3

`define CACHE_S_TAG (32 - `CACHE_S_OFFSET - `CACHE_S_INDEX)

`define CACHE_NUM_SETS (1 << `CACHE_S_INDEX)

// one enable bit per byte of a line
`define CACHE_S_MASK (1 << `CACHE_S_OFFSET)

`define CACHE_S_LINE (8 * `CACHE_S_MASK)

`endif

// ==== src/rv32i_types.sv ====
// core side types
`include "cache_config.svh"

package rv32i_types;

    // address or data word
    typedef logic [31:0] rv32i_word;

    typedef logic [`CACHE_S_MASK-1:0] byte_en_t;   // per byte of a line

endpackage : rv32i_types

// ==== src/cache_types.sv ====
// cache types
`include "cache_config.svh"

package cache_types;

    typedef logic [`CACHE_S_LINE-1:0] line_t;

    typedef logic [`CACHE_S_TAG-1:0] tag_t;
    typedef logic [`CACHE_S_INDEX-1:0] index_t;

    // controller states
    typedef enum logic [1:0] {
        s_check,
        s_writeback,
        s_fetch
    } ctrl_state_e;

    // what gets written into a way
    typedef enum logic {
        src_cpu,
        src_mem
    } data_src_e;

endpackage : cache_types

// ==== src/cache_way_if.sv ====
// cache way interface
`timescale 1ns/1ps

interface cache_way_if;

    logic hit;
    cache_types::tag_t tag;
    logic dirty;
    cache_types::line_t rdata;

    logic load_tag;
    logic set_valid;
    logic set_dirty;
    logic clr_dirty;
    rv32i_types::byte_en_t write_en;
    cache_types::line_t wdata;

    modport way (
        output hit, tag, dirty, rdata,
        input  load_tag, set_valid, set_dirty, clr_dirty, write_en, wdata
    );

    modport sel (
        input  hit, tag, dirty, rdata,
        output load_tag, set_valid, set_dirty, clr_dirty, write_en, wdata
    );

endinterface : cache_way_if

// ==== src/cache_way.sv ====
// single cache way
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_way
(
    input logic clk,
    input logic rst,
    input cache_types::index_t index,
    input cache_types::tag_t req_tag,
    cache_way_if.way port
);

cache_types::tag_t tag_arr [`CACHE_NUM_SETS];
cache_types::line_t data_arr [`CACHE_NUM_SETS];
logic [`CACHE_NUM_SETS-1:0] valid_arr;
logic [`CACHE_NUM_SETS-1:0] dirty_arr;

// combinational read side
assign port.tag   = tag_arr[index];
assign port.rdata = data_arr[index];
assign port.dirty = dirty_arr[index];
assign port.hit   = valid_arr[index] && (tag_arr[index] == req_tag);

// status bits
always_ff @(posedge clk)
begin
    if (rst)
    begin
        valid_arr <= '0;
        dirty_arr <= '0;
    end
    else
    begin
        if (port.set_valid)
        begin
            valid_arr[index] <= 1'b1;
        end
        if (port.set_dirty)
        begin
            dirty_arr[index] <= 1'b1;
        end
        else if (port.clr_dirty)
        begin
            dirty_arr[index] <= 1'b0;
        end
    end
end

// tag and line storage
always_ff @(posedge clk)
begin
    if (port.load_tag)
    begin
        tag_arr[index] <= req_tag;
    end
    for (int i = 0; i < `CACHE_S_MASK; i++)
    begin
        if (port.write_en[i])
        begin
            data_arr[index][8*i +: 8] <= port.wdata[8*i +: 8]; // byte merge
        end
    end
end

endmodule : cache_way

// ==== src/cache_datapath.sv ====
// cache datapath
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_datapath
(
    input logic clk,
    input logic rst,
    input rv32i_types::rv32i_word mem_address,
    input rv32i_types::byte_en_t mem_byte_enable256,
    input cache_types::line_t mem_wdata256,
    input cache_types::line_t pmem_rdata,
    input logic load_line,
    input logic write_hit,
    input logic set_lru,
    input logic addr_sel_victim,
    cache_way_if.sel way0,
    cache_way_if.sel way1,
    output logic hit,
    output logic victim_dirty,
    output cache_types::line_t mem_rdata256,
    output cache_types::line_t pmem_wdata,
    output rv32i_types::rv32i_word pmem_address
);

cache_types::index_t set_idx;
logic [`CACHE_NUM_SETS-1:0] lru_arr;   // 1 means way 1 is lru
logic victim;
cache_types::tag_t victim_tag;
cache_types::data_src_e data_src;
cache_types::line_t wdata;
logic fill0;
logic fill1;

assign set_idx = mem_address[`CACHE_S_OFFSET +: `CACHE_S_INDEX];

assign hit = way0.hit || way1.hit;
assign mem_rdata256 = way1.hit ? way1.rdata : way0.rdata;

// victim is the lru way
assign victim       = lru_arr[set_idx];
assign victim_dirty = victim ? way1.dirty : way0.dirty;
assign victim_tag   = victim ? way1.tag : way0.tag;
assign pmem_wdata   = victim ? way1.rdata : way0.rdata;

always_comb
begin
    if (addr_sel_victim)
    begin
        pmem_address = {victim_tag, set_idx, {`CACHE_S_OFFSET{1'b0}}};
    end
    else
    begin
        pmem_address = {mem_address[31:`CACHE_S_OFFSET], {`CACHE_S_OFFSET{1'b0}}};
    end
end

assign data_src = load_line ? cache_types::src_mem : cache_types::src_cpu;
assign wdata    = (data_src == cache_types::src_mem) ? pmem_rdata : mem_wdata256;

assign fill0 = load_line && !victim;
assign fill1 = load_line && victim;

// way 0 strobes
assign way0.wdata     = wdata;
assign way0.load_tag  = fill0;
assign way0.set_valid = fill0;
assign way0.clr_dirty = fill0;   // refilled line starts clean
assign way0.set_dirty = write_hit && way0.hit;
assign way0.write_en  = fill0 ? '1 : ((write_hit && way0.hit) ? mem_byte_enable256 : '0);

// way 1 strobes
assign way1.wdata     = wdata;
assign way1.load_tag  = fill1;
assign way1.set_valid = fill1;
assign way1.clr_dirty = fill1;
assign way1.set_dirty = write_hit && way1.hit;
assign way1.write_en  = fill1 ? '1 : ((write_hit && way1.hit) ? mem_byte_enable256 : '0);

// lru points away from the way just used
always_ff @(posedge clk)
begin
    if (rst)
    begin
        lru_arr <= '0;
    end
    else if (set_lru)
    begin
        lru_arr[set_idx] <= way0.hit;
    end
end

endmodule : cache_datapath

// ==== src/cache_control.sv ====
// cache controller FSM
`timescale 1ns/1ps

module cache_control
(
    input logic clk,
    input logic rst,
    input logic mem_read,
    input logic mem_write,
    input logic pmem_resp,
    input logic hit,
    input logic victim_dirty,
    output logic mem_resp,
    output logic pmem_read,
    output logic pmem_write,
    output logic load_line,
    output logic write_hit,
    output logic set_lru,
    output logic addr_sel_victim
);

cache_types::ctrl_state_e state;
cache_types::ctrl_state_e state_next;

always_comb
begin
    state_next      = state;
    mem_resp        = 1'b0;
    pmem_read       = 1'b0;
    pmem_write      = 1'b0;
    load_line       = 1'b0;
    write_hit       = 1'b0;
    set_lru         = 1'b0;
    addr_sel_victim = 1'b0;
    unique case (state)
        cache_types::s_check:
        begin
            if (mem_read || mem_write)
            begin
                if (hit)
                begin
                    mem_resp  = 1'b1;   // same cycle response
                    set_lru   = 1'b1;
                    write_hit = mem_write;
                end
                else if (victim_dirty)
                    state_next = cache_types::s_writeback;
                else
                    state_next = cache_types::s_fetch;
            end
        end
        cache_types::s_writeback:
        begin
            pmem_write      = 1'b1;
            addr_sel_victim = 1'b1;   // victim tag and index
            if (pmem_resp)
                state_next = cache_types::s_fetch;
        end
        cache_types::s_fetch:
        begin
            pmem_read = 1'b1;
            if (pmem_resp)
            begin
                load_line  = 1'b1;
                state_next = cache_types::s_check;
            end
        end
        default: state_next = cache_types::s_check;
    endcase
end

always_ff @(posedge clk)
begin
    if (rst)
        state <= cache_types::s_check;
    else
        state <= state_next;
end

endmodule : cache_control

// ==== src/cache.sv ====
// two way cache top
`timescale 1ns/1ps
`include "cache_config.svh"

module cache
(
    input logic clk,
    input logic rst,
    input rv32i_types::rv32i_word mem_address,
    input logic mem_read,
    input logic mem_write,
    input rv32i_types::byte_en_t mem_byte_enable256,
    input cache_types::line_t mem_wdata256,
    input cache_types::line_t pmem_rdata,
    input logic pmem_resp,
    output cache_types::line_t mem_rdata256,
    output logic mem_resp,
    output rv32i_types::rv32i_word pmem_address,
    output logic pmem_read,
    output logic pmem_write,
    output cache_types::line_t pmem_wdata
);

cache_types::index_t set_idx;
cache_types::tag_t req_tag;
logic hit;
logic victim_dirty;
logic load_line;
logic write_hit;
logic set_lru;
logic addr_sel_victim;

assign set_idx = mem_address[`CACHE_S_OFFSET +: `CACHE_S_INDEX];
assign req_tag = mem_address[31 -: `CACHE_S_TAG];

cache_way_if way0_if ();
cache_way_if way1_if ();

cache_way way0 (.clk(clk), .rst(rst), .index(set_idx), .req_tag(req_tag), .port(way0_if));
cache_way way1 (.clk(clk), .rst(rst), .index(set_idx), .req_tag(req_tag), .port(way1_if));

cache_datapath datapath (
    .way0(way0_if),
    .way1(way1_if),
    .*
);

cache_control control (.*);

endmodule : cache

// ==== tb/cache_tb.sv ====
// cache testbench
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_tb;

localparam int num_random = 200;
localparam int max_cycles = (num_random + 16) * 12;   // 12 cycles per request at worst

logic clk;
logic rst;
rv32i_types::rv32i_word mem_address;
logic mem_read;
logic mem_write;
rv32i_types::byte_en_t mem_byte_enable256;
cache_types::line_t mem_wdata256;
cache_types::line_t pmem_rdata;
logic pmem_resp;
cache_types::line_t mem_rdata256;
logic mem_resp;
rv32i_types::rv32i_word pmem_address;
logic pmem_read;
logic pmem_write;
cache_types::line_t pmem_wdata;

cache_types::line_t shadow [rv32i_types::rv32i_word];    // expected contents
cache_types::line_t backing [rv32i_types::rv32i_word];   // memory model contents
rv32i_types::rv32i_word xfer_addr [$];
logic xfer_write [$];
cache_types::line_t wb_data [$];
int cycles;

cache DUT (.*);

function automatic cache_types::line_t fill_line(input rv32i_types::rv32i_word la);
    cache_types::line_t l;
    for (int w = 0; w < `CACHE_S_LINE / 32; w++)
        l[32*w +: 32] = (la ^ 32'h3c5a_96e1) + 32'(w) * 32'h0101_0101;
    return l;
endfunction

// expected line after a write under the byte enable
function automatic cache_types::line_t merge_bytes(input cache_types::line_t old,
        input cache_types::line_t wdata, input rv32i_types::byte_en_t be);
    cache_types::line_t result;
    result = old;
    for (int i = 0; i < `CACHE_S_MASK; i++)
        if (be[i])
            result[8*i +: 8] = wdata[8*i +: 8];
    return result;
endfunction

function automatic rv32i_types::rv32i_word line_of(input rv32i_types::rv32i_word addr);
    return {addr[31:`CACHE_S_OFFSET], {`CACHE_S_OFFSET{1'b0}}};
endfunction

function automatic rv32i_types::rv32i_word make_addr(input int tag, input int idx);
    return (32'(tag) << (`CACHE_S_OFFSET + `CACHE_S_INDEX)) | (32'(idx) << `CACHE_S_OFFSET);
endfunction

function automatic cache_types::line_t shadow_line(input rv32i_types::rv32i_word la);
    return shadow.exists(la) ? shadow[la] : fill_line(la);
endfunction

task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "stopped at first failure");
endtask

task automatic check_line(input string name, input cache_types::line_t got,
        input cache_types::line_t exp);
    if (got !== exp)
        fail_run($sformatf("Error %s got %h expected %h", name, got, exp));
endtask

task automatic check_addr(input string name, input rv32i_types::rv32i_word got,
        input rv32i_types::rv32i_word exp);
    if (got !== exp)
        fail_run($sformatf("Error %s got %h expected %h", name, got, exp));
endtask

task automatic expect_traffic(input int n);
    if (xfer_addr.size() != n)
        fail_run($sformatf("expected %0d memory transfers but saw %0d", n, xfer_addr.size()));
endtask

task automatic clear_log();
    xfer_addr.delete();
    xfer_write.delete();
    wb_data.delete();
endtask

// one cpu request, called on a falling edge, returns on a falling edge
task automatic access(input rv32i_types::rv32i_word addr, input logic wr,
        input rv32i_types::byte_en_t be, input cache_types::line_t wdata);
    mem_address = addr;
    mem_read = !wr;
    mem_write = wr;
    mem_byte_enable256 = be;
    mem_wdata256 = wdata;
    #1;
    while (!mem_resp)
    begin
        @(negedge clk);
        #1;
    end
    if (wr)
        shadow[line_of(addr)] = merge_bytes(shadow_line(line_of(addr)), wdata, be);
    @(negedge clk);
    mem_read = 1'b0;
    mem_write = 1'b0;
endtask

initial
begin
    clk = 1'b0;
    forever #20 clk = ~clk;
end

initial
begin : memory_model
    rv32i_types::rv32i_word addr;
    cache_types::line_t data;
    logic wr;
    pmem_resp = 1'b0;
    pmem_rdata = '0;
    forever
    begin
        @(negedge clk);
        pmem_resp = 1'b0;
        #1;
        if (!rst && (pmem_read || pmem_write))
        begin
            addr = pmem_address;
            wr = pmem_write;
            data = pmem_wdata;
            xfer_addr.push_back(addr);
            xfer_write.push_back(wr);
            if (wr)
                wb_data.push_back(data);
            repeat ($urandom_range(4, 1)) @(negedge clk);
            if (wr)
                backing[addr] = data;
            else
                pmem_rdata = backing.exists(addr) ? backing[addr] : fill_line(addr);
            pmem_resp = 1'b1;
        end
    end
end

initial
begin : read_compare
    forever
    begin
        @(negedge clk);
        #1;
        if (!rst && mem_resp && mem_read)
        begin
            check_line("mem_rdata256", mem_rdata256, shadow_line(line_of(mem_address)));
        end
    end
end

initial
begin : watchdog
    cycles = 0;
    forever
    begin
        @(posedge clk);
        cycles++;
        if (cycles > max_cycles)
            fail_run("simulation timed out");
    end
end

initial
begin : tests
    rv32i_types::rv32i_word a1;
    rv32i_types::rv32i_word addr;
    cache_types::line_t wdata;
    logic wr;
    void'($urandom(32'h96e7_9667));
    rst = 1'b1;
    mem_address = '0;
    mem_read = 1'b0;
    mem_write = 1'b0;
    mem_byte_enable256 = '0;
    mem_wdata256 = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // cold read, one fetch at the line address
    a1 = make_addr(1, 2) + 32'd8;
    clear_log();
    access(a1, 1'b0, '0, '0);
    expect_traffic(1);
    check_addr("pmem_address", xfer_addr[0], line_of(a1));

    // partial write then read back
    for (int w = 0; w < 8; w++)
        wdata[32*w +: 32] = $urandom;
    clear_log();
    access(a1, 1'b1, 32'h00f0_0f0f, wdata);
    access(a1, 1'b0, '0, '0);
    expect_traffic(0);

    access(make_addr(2, 2), 1'b0, '0, '0);   // fills the other way
    clear_log();
    for (int n = 0; n < 4; n++)
        access(make_addr(1 + n % 2, 2), 1'b0, '0, '0);
    expect_traffic(0);

    // tag 1 is lru and dirty now
    clear_log();
    access(make_addr(3, 2), 1'b0, '0, '0);
    expect_traffic(2);
    if (!xfer_write[0] || xfer_write[1])
        fail_run("writeback did not come before the line fetch");
    check_addr("pmem_address", xfer_addr[0], line_of(a1));
    check_line("pmem_wdata", wb_data[0], shadow_line(line_of(a1)));
    check_addr("pmem_address", xfer_addr[1], make_addr(3, 2));

    for (int n = 0; n < num_random; n++)
    begin
        addr = make_addr(4 + $urandom_range(3, 0), $urandom_range(3, 0));
        addr = addr | 32'($urandom_range(31, 0));
        wr = 1'($urandom_range(1, 0));
        for (int w = 0; w < 8; w++)
            wdata[32*w +: 32] = $urandom;
        access(addr, wr, $urandom, wdata);
    end

    @(negedge clk);
    $display("All tests passed");
    $finish;
end

endmodule : cache_tb

// ==== cache.f ====
+incdir+src
src/rv32i_types.sv
src/cache_types.sv
src/cache_way_if.sv
src/cache_way.sv
src/cache_datapath.sv
src/cache_control.sv
src/cache.sv
tb/cache_tb.sv

// ==== run.sh ====
#!/bin/sh
rm -f sim.log
{ verilator --binary --timing -f cache.f --top-module cache_tb -o cache_sim \
    && ./obj_dir/cache_sim; } > sim.log 2>&1 || echo "Some tests failed" >> sim.log
cat sim.log
! grep -q "Some tests failed" sim.log || exit 1
